// ==== rtl/spi_config.svh ====
`ifndef SPI_CONFIG_SVH
`define SPI_CONFIG_SVH

`define SPI_ADDR_CTRL    5'h00
`define SPI_ADDR_STATUS  5'h04
`define SPI_ADDR_RDATA   5'h08
`define SPI_ADDR_WDATA   5'h0C
`define SPI_ADDR_CMD     5'h10

`define SPI_WORD_W       32
`define SPI_CMD_W        14
`define SPI_DIV_W        16
`define SPI_FIFO_DEPTH   8

`define SPI_CTRL_EN      0
`define SPI_CTRL_SRST    1
`define SPI_CTRL_CPHA    2
`define SPI_CTRL_CPOL    3

`define SPI_ST_TX_FULL   0
`define SPI_ST_TX_EMPTY  1
`define SPI_ST_RX_FULL   2
`define SPI_ST_RX_EMPTY  3
`define SPI_ST_CMD_FULL  4
`define SPI_ST_CMD_EMPTY 5
`define SPI_ST_BUSY      6

`endif

// ==== rtl/spi_pkg.sv ====
`include "spi_config.svh"

package spi_pkg;

    typedef logic [`SPI_WORD_W-1:0] word_t;

    typedef logic [`SPI_DIV_W-1:0] div_t;

    typedef enum logic [1:0] {
        DIR_NONE = 2'd0,
        DIR_RX   = 2'd1,
        DIR_TX   = 2'd2
    } spi_dir_e;

    // command word as written to the CMD register
    typedef struct packed {
        spi_dir_e   dir;      // 13:12
        logic [1:0] rsvd_hi;  // unused
        logic       hold;     // keep cs low afterwards
        logic       rsvd_lo;  // unused
        logic [7:0] cnt;      // words minus one
    } cmd_t;

endpackage

// ==== rtl/spi_fifo.sv ====
`timescale 1ns/1ps

module spi_fifo #(
    parameter type T     = logic [31:0],
    parameter int  DEPTH = 8
) (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic flush_i,
    input  logic push_i,
    input  T     data_i,
    input  logic pop_i,
    output T     data_o,
    output logic full_o,
    output logic empty_o
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) wr_ptr_q <= ptr_inc(wr_ptr_q);
            if (pop_i) rd_ptr_q <= ptr_inc(rd_ptr_q);
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;  // both or neither
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) mem_q[wr_ptr_q] <= data_i;
    end

    assign data_o  = mem_q[rd_ptr_q];  // head, no read latency
    assign full_o  = (count_q == CNT_W'(DEPTH));
    assign empty_o = (count_q == '0);

endmodule

// ==== rtl/spi_regs.sv ====
`timescale 1ns/1ps
`include "spi_config.svh"

module spi_regs (
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  logic           req_i,
    input  logic           we_i,
    input  logic [4:0]     addr_i,
    input  spi_pkg::word_t wdata_i,
    output logic           done_o,
    output spi_pkg::word_t rdata_o,
    output logic           en_o,
    output logic           cpha_o,
    output logic           cpol_o,
    output spi_pkg::div_t  div_o,
    output logic           flush_o,
    output logic           cmd_push_o,
    output spi_pkg::cmd_t  cmd_o,
    output logic           tx_push_o,
    output spi_pkg::word_t tx_word_o,
    output logic           rx_pop_o,
    input  spi_pkg::word_t rx_word_i,
    input  logic           cmd_full_i,
    input  logic           cmd_empty_i,
    input  logic           tx_full_i,
    input  logic           tx_empty_i,
    input  logic           rx_full_i,
    input  logic           rx_empty_i,
    input  logic           busy_i
);
    spi_pkg::word_t ctrl_q;
    spi_pkg::word_t status_w;
    spi_pkg::word_t rd_mux_w;
    spi_pkg::word_t rdata_q;
    logic           done_q;
    logic           access_w;
    logic           wr_w;
    logic           rd_w;

    // only the first cycle of a request counts
    assign access_w = req_i & ~done_q;
    assign wr_w     = access_w & we_i;
    assign rd_w     = access_w & ~we_i;

    always_comb begin
        status_w                    = '0;
        status_w[`SPI_ST_TX_FULL]   = tx_full_i;
        status_w[`SPI_ST_TX_EMPTY]  = tx_empty_i;
        status_w[`SPI_ST_RX_FULL]   = rx_full_i;
        status_w[`SPI_ST_RX_EMPTY]  = rx_empty_i;
        status_w[`SPI_ST_CMD_FULL]  = cmd_full_i;
        status_w[`SPI_ST_CMD_EMPTY] = cmd_empty_i;
        status_w[`SPI_ST_BUSY]      = busy_i;
    end

    always_comb begin
        case (addr_i)
            `SPI_ADDR_CTRL:   rd_mux_w = ctrl_q;
            `SPI_ADDR_STATUS: rd_mux_w = status_w;
            `SPI_ADDR_RDATA:  rd_mux_w = rx_empty_i ? '0 : rx_word_i;
            default:          rd_mux_w = '0;  // write-only or unmapped
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ctrl_q <= '0;
        end else if (ctrl_q[`SPI_CTRL_SRST]) begin
            ctrl_q <= '0;  // soft reset lasts one cycle
        end else if (wr_w && addr_i == `SPI_ADDR_CTRL) begin
            ctrl_q <= wdata_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            done_q <= 1'b0;
        end else begin
            done_q <= access_w;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_w) rdata_q <= rd_mux_w;
    end

    // queue side effects, dropped when the flag says no room or no data
    assign cmd_push_o = wr_w && addr_i == `SPI_ADDR_CMD && !cmd_full_i;
    assign tx_push_o  = wr_w && addr_i == `SPI_ADDR_WDATA && !tx_full_i;
    assign rx_pop_o   = rd_w && addr_i == `SPI_ADDR_RDATA && !rx_empty_i;
    assign cmd_o      = spi_pkg::cmd_t'(wdata_i[`SPI_CMD_W-1:0]);
    assign tx_word_o  = wdata_i;

    assign en_o    = ctrl_q[`SPI_CTRL_EN];
    assign flush_o = ctrl_q[`SPI_CTRL_SRST];
    assign cpha_o  = ctrl_q[`SPI_CTRL_CPHA];
    assign cpol_o  = ctrl_q[`SPI_CTRL_CPOL];
    assign div_o   = ctrl_q[31:16];

    assign done_o  = done_q;
    assign rdata_o = rdata_q;

endmodule

// ==== rtl/spi_engine.sv ====
`timescale 1ns/1ps
`include "spi_config.svh"

module spi_engine (
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  logic           flush_i,
    input  logic           en_i,
    input  logic           cpha_i,
    input  logic           cpol_i,
    input  spi_pkg::div_t  div_i,
    input  spi_pkg::cmd_t  cmd_i,
    input  logic           cmd_empty_i,
    input  spi_pkg::word_t tx_word_i,
    input  logic           tx_empty_i,
    input  logic           rx_full_i,
    input  logic           miso_i,
    output logic           cmd_pop_o,
    output logic           tx_pop_o,
    output logic           rx_push_o,
    output spi_pkg::word_t rx_word_o,
    output logic           busy_o,
    output logic           sck_o,
    output logic           cs_o,
    output logic           mosi_o
);
    localparam int EDGE_W = $clog2(2 * `SPI_WORD_W);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WSTART,
        ST_SHIFT,
        ST_FINISH
    } state_e;

    state_e            state_q;
    spi_pkg::cmd_t     cmd_q;
    spi_pkg::div_t     div_cnt_q;
    logic [EDGE_W-1:0] edge_q;
    logic [7:0]        word_q;
    spi_pkg::word_t    sh_q;
    logic              sck_q;
    logic              cs_q;
    logic              rx_push_q;
    logic              is_tx_w;
    logic              is_rx_w;
    logic              tick_w;
    logic              sample_w;
    logic              shift_w;
    logic              start_w;
    logic              cmd_ok_w;
    logic              word_go_w;

    assign is_tx_w  = cmd_q.dir == spi_pkg::DIR_TX;
    assign is_rx_w  = cmd_q.dir == spi_pkg::DIR_RX;
    assign cmd_ok_w = cmd_i.dir == spi_pkg::DIR_TX || cmd_i.dir == spi_pkg::DIR_RX;
    assign tick_w   = div_cnt_q == div_i;  // end of a half period

    // even edge index is the leading edge
    assign sample_w = state_q == ST_SHIFT && tick_w && edge_q[0] == cpha_i;
    assign shift_w  = state_q == ST_SHIFT && tick_w && edge_q[0] != cpha_i && edge_q != '0;
    assign start_w  = state_q == ST_IDLE && en_i && !cmd_empty_i && !flush_i;
    // rx push still in flight counts as full
    assign word_go_w = state_q == ST_WSTART && !flush_i &&
                       (is_tx_w ? !tx_empty_i : (!rx_full_i && !rx_push_q));

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q   <= ST_IDLE;
            div_cnt_q <= '0;
            edge_q    <= '0;
            word_q    <= '0;
            sck_q     <= 1'b0;
            cs_q      <= 1'b1;
            rx_push_q <= 1'b0;
        end else if (flush_i) begin
            state_q   <= ST_IDLE;
            div_cnt_q <= '0;
            edge_q    <= '0;
            word_q    <= '0;
            sck_q     <= 1'b0;
            cs_q      <= 1'b1;
            rx_push_q <= 1'b0;
        end else begin
            rx_push_q <= sample_w && is_rx_w && edge_q[EDGE_W-1:1] == '1;
            case (state_q)
                ST_IDLE: begin
                    sck_q <= cpol_i;
                    if (start_w && cmd_ok_w) begin  // other directions are dropped
                        state_q <= ST_WSTART;
                        cs_q    <= 1'b0;
                        word_q  <= '0;
                    end
                end
                ST_WSTART: begin
                    if (word_go_w) begin
                        state_q   <= ST_SHIFT;
                        div_cnt_q <= '0;
                        edge_q    <= '0;
                    end
                end
                ST_SHIFT: begin
                    if (tick_w) begin
                        div_cnt_q <= '0;
                        sck_q     <= ~sck_q;
                        edge_q    <= edge_q + 1'b1;
                        if (edge_q == '1) begin
                            if (word_q == cmd_q.cnt) begin
                                state_q <= ST_FINISH;
                            end else begin
                                word_q  <= word_q + 1'b1;
                                state_q <= ST_WSTART;
                            end
                        end
                    end else begin
                        div_cnt_q <= div_cnt_q + 1'b1;
                    end
                end
                ST_FINISH: begin
                    if (tick_w) begin  // half period of cs hold time
                        state_q <= ST_IDLE;
                        cs_q    <= ~cmd_q.hold;
                    end else begin
                        div_cnt_q <= div_cnt_q + 1'b1;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_w) cmd_q <= cmd_i;
        if (word_go_w && is_tx_w) begin
            sh_q <= tx_word_i;
        end else if (shift_w && is_tx_w) begin
            sh_q <= {1'b0, sh_q[`SPI_WORD_W-1:1]};  // lsb first out
        end else if (sample_w && is_rx_w) begin
            sh_q <= {miso_i, sh_q[`SPI_WORD_W-1:1]};  // first bit lands in bit 0
        end
    end

    assign cmd_pop_o = start_w;
    assign tx_pop_o  = word_go_w && is_tx_w;
    assign rx_push_o = rx_push_q;
    assign rx_word_o = sh_q;
    assign busy_o    = state_q != ST_IDLE;
    assign sck_o     = busy_o ? sck_q : cpol_i;
    assign cs_o      = cs_q;
    // head bit shown early so it is valid when cs falls
    assign mosi_o    = busy_o && is_tx_w &&
                       ((state_q == ST_WSTART && !tx_empty_i) ? tx_word_i[0] : sh_q[0]);

endmodule

// ==== rtl/spi_master.sv ====
`timescale 1ns/1ps
`include "spi_config.svh"

module spi_master (
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  logic           req_i,
    input  logic           we_i,
    input  logic [4:0]     addr_i,
    input  spi_pkg::word_t wdata_i,
    output logic           done_o,
    output spi_pkg::word_t rdata_o,
    output logic           sck_o,
    output logic           cs_o,
    output logic           mosi_o,
    input  logic           miso_i
);
    logic           en;
    logic           cpha;
    logic           cpol;
    spi_pkg::div_t  div;
    logic           flush;
    logic           busy;
    logic           cmd_push;
    logic           cmd_pop;
    logic           cmd_full;
    logic           cmd_empty;
    spi_pkg::cmd_t  cmd_in;
    spi_pkg::cmd_t  cmd_head;
    logic           tx_push;
    logic           tx_pop;
    logic           tx_full;
    logic           tx_empty;
    spi_pkg::word_t tx_in;
    spi_pkg::word_t tx_head;
    logic           rx_push;
    logic           rx_pop;
    logic           rx_full;
    logic           rx_empty;
    spi_pkg::word_t rx_in;
    spi_pkg::word_t rx_head;

    spi_regs regs0 (
        .clk_i, .rst_n_i, .req_i, .we_i, .addr_i, .wdata_i, .done_o, .rdata_o,
        .en_o(en), .cpha_o(cpha), .cpol_o(cpol), .div_o(div), .flush_o(flush),
        .cmd_push_o(cmd_push), .cmd_o(cmd_in), .tx_push_o(tx_push), .tx_word_o(tx_in),
        .rx_pop_o(rx_pop), .rx_word_i(rx_head),
        .cmd_full_i(cmd_full), .cmd_empty_i(cmd_empty), .tx_full_i(tx_full),
        .tx_empty_i(tx_empty), .rx_full_i(rx_full), .rx_empty_i(rx_empty), .busy_i(busy)
    );

    spi_fifo #(.T(spi_pkg::cmd_t), .DEPTH(`SPI_FIFO_DEPTH)) cmd_fifo0 (
        .clk_i, .rst_n_i, .flush_i(flush), .push_i(cmd_push), .data_i(cmd_in),
        .pop_i(cmd_pop), .data_o(cmd_head), .full_o(cmd_full), .empty_o(cmd_empty)
    );

    spi_fifo #(.T(spi_pkg::word_t), .DEPTH(`SPI_FIFO_DEPTH)) tx_fifo0 (
        .clk_i, .rst_n_i, .flush_i(flush), .push_i(tx_push), .data_i(tx_in),
        .pop_i(tx_pop), .data_o(tx_head), .full_o(tx_full), .empty_o(tx_empty)
    );

    spi_fifo #(.T(spi_pkg::word_t), .DEPTH(`SPI_FIFO_DEPTH)) rx_fifo0 (
        .clk_i, .rst_n_i, .flush_i(flush), .push_i(rx_push), .data_i(rx_in),
        .pop_i(rx_pop), .data_o(rx_head), .full_o(rx_full), .empty_o(rx_empty)
    );

    spi_engine engine0 (
        .clk_i, .rst_n_i, .flush_i(flush), .en_i(en), .cpha_i(cpha), .cpol_i(cpol),
        .div_i(div), .cmd_i(cmd_head), .cmd_empty_i(cmd_empty), .tx_word_i(tx_head),
        .tx_empty_i(tx_empty), .rx_full_i(rx_full), .miso_i,
        .cmd_pop_o(cmd_pop), .tx_pop_o(tx_pop), .rx_push_o(rx_push), .rx_word_o(rx_in),
        .busy_o(busy), .sck_o, .cs_o, .mosi_o
    );

endmodule

// ==== verification/spi_assertions.sv ====
`timescale 1ns/1ps

module spi_assertions (
    input logic clk_i,
    input logic rst_n_i,
    input logic done_i,
    input logic sck_i,
    input logic cs_i,
    input logic busy_i,
    input logic cpol_i
);
    int fail_count = 0;

    property done_single_p;
        @(posedge clk_i) disable iff (!rst_n_i) done_i |=> !done_i;
    endproperty

    // deselected clock only moves with a CPOL change
    property sck_quiet_p;
        @(posedge clk_i) disable iff (!rst_n_i)
            (cs_i && $past(cs_i) && cpol_i == $past(cpol_i)) |-> sck_i == $past(sck_i);
    endproperty

    // clock already at idle level in the last busy cycle
    property idle_level_p;
        @(posedge clk_i) disable iff (!rst_n_i) !busy_i |-> $past(sck_i) == $past(cpol_i);
    endproperty

    done_single_a: assert property (done_single_p) else begin
        fail_count++;
        $error("done_o high for two cycles");
    end

    sck_quiet_a: assert property (sck_quiet_p) else begin
        fail_count++;
        $error("sck_o toggled while cs_o high");
    end

    idle_level_a: assert property (idle_level_p) else begin
        fail_count++;
        $error("sck_o differs from CPOL while idle");
    end

endmodule

// ==== verification/spi_tb.sv ====
`timescale 1ns/1ps
`include "spi_config.svh"

module spi_tb;
    localparam int DIV_REG = 3;
    localparam int DIV_TX  = 2;
    localparam int DIV_RX  = 1;
    // per word: 64 half periods, the cs hold half period and the word start
    localparam int TX_CYCLES  = 2 * (65 * (DIV_TX + 1) + 2);
    localparam int RX_CYCLES  = 3 * (65 * (DIV_RX + 1) + 2);
    localparam int TIMEOUT_NS = (TX_CYCLES + RX_CYCLES + 1000) * 10;
    localparam spi_pkg::word_t ST_RESET = (1 << `SPI_ST_TX_EMPTY) | (1 << `SPI_ST_RX_EMPTY) |
                                          (1 << `SPI_ST_CMD_EMPTY);

    logic           clk;
    logic           rst_n;
    logic           req;
    logic           we;
    logic [4:0]     addr;
    spi_pkg::word_t wdata;
    logic           done;
    spi_pkg::word_t rdata;
    logic           sck;
    logic           cs;
    logic           mosi;
    logic           miso        = 1'b0;
    int             error_count = 0;
    int             test_count  = 0;
    spi_pkg::word_t lcg_state   = 32'h6757;

    // slave model state
    logic           m_cpol      = 1'b0;
    logic           m_cpha      = 1'b0;
    spi_pkg::word_t miso_q[$];   // words to send
    spi_pkg::word_t mosi_q[$];   // words captured
    int             half_q[$];   // in-word half periods, cycles
    spi_pkg::word_t cap_word    = '0;
    spi_pkg::word_t out_word    = '0;
    int             cap_bit     = 0;
    int             out_bit     = 0;
    int             toggles     = 0;
    int             cyc         = 0;
    int             last_toggle = 0;
    logic           sck_prev    = 1'b0;
    logic           cs_prev     = 1'b1;

    spi_master dut0 (
        .clk_i(clk), .rst_n_i(rst_n), .req_i(req), .we_i(we), .addr_i(addr),
        .wdata_i(wdata), .done_o(done), .rdata_o(rdata), .sck_o(sck), .cs_o(cs),
        .mosi_o(mosi), .miso_i(miso)
    );

    bind spi_master spi_assertions asrt0 (
        .clk_i, .rst_n_i, .done_i(done_o), .sck_i(sck_o), .cs_i(cs_o),
        .busy_i(busy), .cpol_i(cpol)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic spi_pkg::word_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic spi_pkg::word_t ctrl_word(input int div, input logic cpol,
                                                 input logic cpha, input logic en);
        spi_pkg::word_t w;
        w                 = '0;
        w[31:16]          = div[15:0];
        w[`SPI_CTRL_CPOL] = cpol;
        w[`SPI_CTRL_CPHA] = cpha;
        w[`SPI_CTRL_EN]   = en;
        return w;
    endfunction

    function automatic spi_pkg::word_t cmd_word(input spi_pkg::spi_dir_e dir, input logic hold,
                                                input int words);
        spi_pkg::cmd_t c;
        c      = '0;
        c.dir  = dir;
        c.hold = hold;
        c.cnt  = 8'(words - 1);
        return {18'd0, c};
    endfunction

    task automatic report_mismatch(input string name, input spi_pkg::word_t exp,
                                   input spi_pkg::word_t act);
        error_count++;
        $display("Mismatch at time %0t: %s expected 0x%h actual 0x%h", $time, name, exp, act);
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_count++;
        if (error_count == errs_before) $display("test %s: ok", name);
        else $display("test %s: %0d errors", name, error_count - errs_before);
    endtask

    task automatic bus_cycle(input logic is_write, input logic [4:0] a,
                             input spi_pkg::word_t wd, output spi_pkg::word_t rd);
        int lat;
        @(posedge clk);
        #1;
        req   = 1'b1;
        we    = is_write;
        addr  = a;
        wdata = wd;
        lat   = 0;
        do begin
            @(posedge clk);
            #1;
            lat++;
        end while (!done && lat < 2);
        rd  = rdata;
        req = 1'b0;
        we  = 1'b0;
        if (!done) begin
            error_count++;
            $display("Error at time %0t: no done_o within two cycles of access to 0x%h",
                     $time, a);
        end else if (lat != 1) begin
            report_mismatch("done_o latency", 1, lat);
        end
    endtask

    task automatic bus_write(input logic [4:0] a, input spi_pkg::word_t wd);
        spi_pkg::word_t unused;
        bus_cycle(1'b1, a, wd, unused);
    endtask

    task automatic bus_read(input logic [4:0] a, output spi_pkg::word_t rd);
        bus_cycle(1'b0, a, '0, rd);
    endtask

    task automatic wait_idle(input int max_polls);
        spi_pkg::word_t st;
        int n;
        n = 0;
        do begin
            bus_read(`SPI_ADDR_STATUS, st);
            n++;
        end while (st[`SPI_ST_BUSY] && n < max_polls);
        if (st[`SPI_ST_BUSY]) begin
            error_count++;
            $display("Error at time %0t: transfer still busy after %0d polls", $time, n);
        end
    endtask

    task automatic clear_slave(input logic cpol, input logic cpha);
        m_cpol = cpol;
        m_cpha = cpha;
        miso_q.delete();
        mosi_q.delete();
        half_q.delete();
    endtask

    task automatic drive_miso_bit();
        if (out_bit == 0) begin
            if (miso_q.size() > 0) out_word = miso_q.pop_front();
            else out_word = '0;
        end
        miso    = out_word[out_bit];  // lsb first
        out_bit = (out_bit + 1) % 32;
    endtask

    // slave model runs on the falling edge, where DUT outputs have settled
    always @(negedge clk) begin
        cyc++;
        if (cs_prev && !cs) begin
            cap_bit = 0;
            out_bit = 0;
            toggles = 0;
            if (!m_cpha) drive_miso_bit();  // first bit ready at select
        end
        if (!cs && sck != sck_prev) begin
            if (toggles % 64 != 0) half_q.push_back(cyc - last_toggle);
            last_toggle = cyc;
            toggles++;
            if ((sck != m_cpol) != m_cpha) begin  // sample edge
                cap_word[cap_bit] = mosi;
                cap_bit++;
                if (cap_bit == 32) begin
                    mosi_q.push_back(cap_word);
                    cap_bit = 0;
                end
            end else begin
                drive_miso_bit();
            end
        end
        sck_prev = sck;
        cs_prev  = cs;
    end

    task automatic check_reset_state();
        spi_pkg::word_t rd;
        int errs;
        errs = error_count;
        bus_read(`SPI_ADDR_STATUS, rd);
        if (rd != ST_RESET) report_mismatch("STATUS", ST_RESET, rd);
        bus_read(`SPI_ADDR_CTRL, rd);
        if (rd != '0) report_mismatch("CTRL", '0, rd);
        if (cs !== 1'b1) report_mismatch("cs_o", 1, {31'd0, cs});
        if (sck !== 1'b0) report_mismatch("sck_o", 0, {31'd0, sck});
        report_test("reset state", errs);
    endtask

    task automatic check_register_access();
        spi_pkg::word_t rd;
        spi_pkg::word_t wr;
        int errs;
        errs = error_count;
        wr   = ctrl_word(DIV_REG, 1'b1, 1'b1, 1'b0);
        bus_write(`SPI_ADDR_CTRL, wr);
        bus_read(`SPI_ADDR_CTRL, rd);
        if (rd != wr) report_mismatch("CTRL", wr, rd);
        bus_write(`SPI_ADDR_STATUS, 32'hFFFF_FFFF);
        bus_read(`SPI_ADDR_STATUS, rd);
        if (rd != ST_RESET) report_mismatch("STATUS", ST_RESET, rd);
        bus_read(`SPI_ADDR_WDATA, rd);
        if (rd != '0) report_mismatch("WDATA read", '0, rd);
        bus_read(`SPI_ADDR_CMD, rd);
        if (rd != '0) report_mismatch("CMD read", '0, rd);
        bus_read(`SPI_ADDR_RDATA, rd);
        if (rd != '0) report_mismatch("RDATA empty read", '0, rd);
        bus_write(`SPI_ADDR_CTRL, '0);
        report_test("register access", errs);
    endtask

    task automatic run_tx_mode0();
        spi_pkg::word_t w0;
        spi_pkg::word_t w1;
        spi_pkg::word_t rd;
        int errs;
        errs = error_count;
        clear_slave(1'b0, 1'b0);
        w0 = lcg_next();
        w1 = lcg_next();
        bus_write(`SPI_ADDR_WDATA, w0);
        bus_write(`SPI_ADDR_WDATA, w1);
        bus_write(`SPI_ADDR_CMD, cmd_word(spi_pkg::DIR_TX, 1'b0, 2));
        bus_write(`SPI_ADDR_CTRL, ctrl_word(DIV_TX, 1'b0, 1'b0, 1'b1));
        wait_idle(TX_CYCLES);
        if (mosi_q.size() != 2) begin
            report_mismatch("captured word count", 2, mosi_q.size());
        end else begin
            if (mosi_q[0] != w0) report_mismatch("mosi_o word 0", w0, mosi_q[0]);
            if (mosi_q[1] != w1) report_mismatch("mosi_o word 1", w1, mosi_q[1]);
        end
        if (half_q.size() != 126) report_mismatch("sck_o half period count", 126, half_q.size());
        for (int i = 0; i < half_q.size(); i++) begin
            if (half_q[i] != DIV_TX + 1) begin
                report_mismatch("sck_o half period", DIV_TX + 1, half_q[i]);
                break;  // one line is enough
            end
        end
        if (cs !== 1'b1) report_mismatch("cs_o", 1, {31'd0, cs});
        bus_read(`SPI_ADDR_STATUS, rd);
        if (rd != ST_RESET) report_mismatch("STATUS", ST_RESET, rd);
        bus_write(`SPI_ADDR_CTRL, '0);
        report_test("transmit mode 0", errs);
    endtask

    task automatic run_rx_mode3_hold();
        spi_pkg::word_t exp [3];
        spi_pkg::word_t rd;
        int errs;
        errs = error_count;
        clear_slave(1'b1, 1'b1);
        for (int i = 0; i < 3; i++) begin
            exp[i] = lcg_next();
            miso_q.push_back(exp[i]);
        end
        bus_write(`SPI_ADDR_CMD, cmd_word(spi_pkg::DIR_RX, 1'b1, 3));
        bus_write(`SPI_ADDR_CTRL, ctrl_word(DIV_RX, 1'b1, 1'b1, 1'b1));
        wait_idle(RX_CYCLES);
        for (int i = 0; i < 3; i++) begin
            bus_read(`SPI_ADDR_RDATA, rd);
            if (rd != exp[i]) report_mismatch("RDATA", exp[i], rd);
        end
        bus_read(`SPI_ADDR_RDATA, rd);
        if (rd != '0) report_mismatch("RDATA empty read", '0, rd);
        if (cs !== 1'b0) report_mismatch("cs_o", 0, {31'd0, cs});  // hold keeps select
        report_test("receive mode 3 hold", errs);
    endtask

    task automatic check_queue_limits();
        spi_pkg::word_t rd;
        spi_pkg::word_t exp;
        int errs;
        errs = error_count;
        bus_write(`SPI_ADDR_CTRL, '0);
        for (int i = 0; i < `SPI_FIFO_DEPTH + 1; i++) begin
            bus_write(`SPI_ADDR_CMD, cmd_word(spi_pkg::DIR_TX, 1'b0, 1));
            bus_write(`SPI_ADDR_WDATA, lcg_next());
        end
        exp = (1 << `SPI_ST_TX_FULL) | (1 << `SPI_ST_RX_EMPTY) | (1 << `SPI_ST_CMD_FULL);
        bus_read(`SPI_ADDR_STATUS, rd);
        if (rd != exp) report_mismatch("STATUS", exp, rd);
        bus_write(`SPI_ADDR_CTRL, ctrl_word(0, 1'b0, 1'b0, 1'b1) | (1 << `SPI_CTRL_SRST));
        bus_read(`SPI_ADDR_STATUS, rd);
        if (rd != ST_RESET) report_mismatch("STATUS", ST_RESET, rd);
        bus_read(`SPI_ADDR_CTRL, rd);
        if (rd != '0) report_mismatch("CTRL", '0, rd);
        // head slot still holds an old received word
        bus_read(`SPI_ADDR_RDATA, rd);
        if (rd != '0) report_mismatch("RDATA empty read", '0, rd);
        repeat (20) @(posedge clk);
        bus_read(`SPI_ADDR_STATUS, rd);
        if (rd != ST_RESET) report_mismatch("STATUS", ST_RESET, rd);
        if (cs !== 1'b1) report_mismatch("cs_o", 1, {31'd0, cs});
        report_test("queue limits and soft reset", errs);
    endtask

    initial begin
        int total;
        rst_n = 1'b0;
        req   = 1'b0;
        we    = 1'b0;
        addr  = '0;
        wdata = '0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_reset_state();
        check_register_access();
        run_tx_mode0();
        run_rx_mode3_hold();
        check_queue_limits();
        repeat (2) @(posedge clk);
        total = error_count + dut0.asrt0.fail_count;
        $display("summary: %0d tests, %0d check errors, %0d assertion failures",
                 test_count, error_count, dut0.asrt0.fail_count);
        if (total == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Error at time %0t: watchdog expired before the tests completed", $time);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+rtl
rtl/spi_pkg.sv
rtl/spi_fifo.sv
rtl/spi_regs.sv
rtl/spi_engine.sv
rtl/spi_master.sv
verification/spi_assertions.sv
verification/spi_tb.sv

// ==== Makefile ====
# Verilator flow for the SPI master testbench

VERILATOR ?= verilator
TOP       ?= spi_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= *** PASSED ***

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
